// ==== design/bit_sync.sv ====
/* Two flop synchroniser for a single level signal. Not for pulses shorter
   than two clk periods */
`timescale 1ns/1ps

module bit_sync (
    input  logic clk,
    input  logic reset,
    input  logic d,
    output logic q
);

    logic meta;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            meta <= 1'b0;
            q    <= 1'b0;
        end else begin
            meta <= d;
            q    <= meta;
        end
    end

endmodule

// ==== design/crtc_timing.sv ====
/* Raster timing on vga_clk with 8x8 character cells. Syncs are active low and
   all four outputs are registered together. Configuration is sampled directly
   from the bus clock domain */
`timescale 1ns/1ps

module crtc_timing #(
    parameter int cols    = 4,
    parameter int rows    = 2,
    parameter int h_front = 4,
    parameter int h_sync  = 4,
    parameter int h_back  = 4,
    parameter int v_front = 2,
    parameter int v_sync  = 2,
    parameter int v_back  = 2
) (
    input  logic        vga_clk,
    input  logic        reset,
    display_cfg_if.crtc cfg,
    output logic        hsync,
    output logic        vsync,
    output logic        video_active,
    output logic        cursor_on
);
    import vga_pkg::*;

    localparam int h_visible = cols * 8;
    localparam int v_visible = rows * 8;
    localparam int h_total   = h_visible + h_front + h_sync + h_back;
    localparam int v_total   = v_visible + v_front + v_sync + v_back;
    localparam int hw        = $clog2(h_total);
    localparam int vw        = $clog2(v_total);

    raster_phase_t h_phase;
    raster_phase_t v_phase;
    logic [hw-1:0] h_count;
    logic [hw-1:0] h_end;
    logic [vw-1:0] v_count;
    logic [vw-1:0] v_end;
    logic          h_last;
    logic          v_last;
    logic          line_end;
    logic          visible;
    cursor_pos_t   char_pos;
    scan_line_t    scan;
    logic          pos_match;
    logic          scan_match;

    function automatic raster_phase_t next_phase(raster_phase_t phase);
        case (phase)
            PHASE_VISIBLE: next_phase = PHASE_FRONT;
            PHASE_FRONT:   next_phase = PHASE_SYNC;
            PHASE_SYNC:    next_phase = PHASE_BACK;
            default:       next_phase = PHASE_VISIBLE;
        endcase
    endfunction

    // last count of the current phase as the counters restart in every phase
    always_comb begin
        case (h_phase)
            PHASE_VISIBLE: h_end = hw'(h_visible - 1);
            PHASE_FRONT:   h_end = hw'(h_front - 1);
            PHASE_SYNC:    h_end = hw'(h_sync - 1);
            default:       h_end = hw'(h_back - 1);
        endcase
        case (v_phase)
            PHASE_VISIBLE: v_end = vw'(v_visible - 1);
            PHASE_FRONT:   v_end = vw'(v_front - 1);
            PHASE_SYNC:    v_end = vw'(v_sync - 1);
            default:       v_end = vw'(v_back - 1);
        endcase
    end

    assign h_last   = h_count == h_end;
    assign v_last   = v_count == v_end;
    assign line_end = h_last && h_phase == PHASE_BACK;

    always_ff @(posedge vga_clk or posedge reset) begin
        if (reset) begin
            h_phase <= PHASE_VISIBLE;
            h_count <= '0;
        end else if (h_last) begin
            h_phase <= next_phase(h_phase);
            h_count <= '0;
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    // the line counter steps once per complete line
    always_ff @(posedge vga_clk or posedge reset) begin
        if (reset) begin
            v_phase <= PHASE_VISIBLE;
            v_count <= '0;
        end else if (line_end) begin
            if (v_last) begin
                v_phase <= next_phase(v_phase);
                v_count <= '0;
            end else begin
                v_count <= v_count + 1'b1;
            end
        end
    end

    // in the visible phases the counters are the pixel x and y
    assign visible  = h_phase == PHASE_VISIBLE && v_phase == PHASE_VISIBLE;
    assign scan     = v_count[2:0];
    assign char_pos = cursor_pos_t'(v_count[vw-1:3]) * cursor_pos_t'(cols)
                    + cursor_pos_t'(h_count[hw-1:3]);

    assign pos_match  = char_pos == cfg.cursor_pos;
    assign scan_match = scan >= cfg.cursor_scan_start && scan <= cfg.cursor_scan_end;

    always_ff @(posedge vga_clk or posedge reset) begin
        if (reset) begin
            hsync        <= 1'b1;
            vsync        <= 1'b1;
            video_active <= 1'b0;
            cursor_on    <= 1'b0;
        end else begin
            hsync        <= h_phase != PHASE_SYNC;
            vsync        <= v_phase != PHASE_SYNC;
            video_active <= visible && cfg.display_enabled;
            cursor_on    <= visible && cfg.display_enabled && cfg.cursor_enabled
                            && pos_match && scan_match;
        end
    end

endmodule

// ==== design/display_cfg_if.sv ====
/* Display configuration from the bus register block to the raster timing.
   Plain levels with no synchronisation, so they are only changed during
   vertical retrace */
`timescale 1ns/1ps

interface display_cfg_if;
    import vga_pkg::*;

    logic        display_enabled;
    logic        cursor_enabled;
    cursor_pos_t cursor_pos;
    scan_line_t  cursor_scan_start;
    scan_line_t  cursor_scan_end;

    modport regs (
        output display_enabled,
        output cursor_enabled,
        output cursor_pos,
        output cursor_scan_start,
        output cursor_scan_end
    );

    modport crtc (
        input display_enabled,
        input cursor_enabled,
        input cursor_pos,
        input cursor_scan_start,
        input cursor_scan_end
    );

endinterface

// ==== design/vga_pkg.sv ====
/* Shared types of the text display controller. Character cells are fixed
   at 8 by 8 pixels, which sets the scan line width */
package vga_pkg;

    // bus side, word addressed with two byte lanes
    typedef logic [19:1] bus_addr_t;
    typedef logic [15:0] bus_data_t;
    typedef logic [1:0]  bus_bytesel_t;

    // CRTC index selected through the index register
    typedef logic [3:0] reg_index_t;

    // linear character position, row * cols + column
    typedef logic [14:0] cursor_pos_t;

    // line inside a character cell
    typedef logic [2:0] scan_line_t;

    typedef logic [3:0] color_t;

    // both raster counters walk through the same four phases in this order
    typedef enum logic [1:0] {
        PHASE_VISIBLE,
        PHASE_FRONT,
        PHASE_SYNC,
        PHASE_BACK
    } raster_phase_t;

endpackage

// ==== design/vga_registers.sv ====
/* Bus register block of the text display controller. Every access with cs is
   answered by a single cycle ack, read data is registered with it and is zero
   otherwise. Only CRTC indices 0xA, 0xB, 0xE and 0xF exist */
`timescale 1ns/1ps
`include "vga_regs.svh"

module vga_registers (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cs,
    input  vga_pkg::bus_addr_t    addr,
    input  vga_pkg::bus_data_t    wdata,
    output vga_pkg::bus_data_t    rdata,
    input  vga_pkg::bus_bytesel_t bytesel,
    input  logic                  wr_en,
    input  logic                  access,
    output logic                  ack,
    input  logic                  vga_hsync,
    input  logic                  vga_vsync,
    display_cfg_if.regs           cfg
);
    import vga_pkg::*;

    logic        reg_access;
    logic        sel_index;
    logic        sel_value;
    logic        sel_mode;
    logic        sel_color;
    logic        sel_status;
    reg_index_t  active_index;
    reg_index_t  index;
    logic [7:0]  value_byte;
    logic [7:0]  index_value;
    logic [7:0]  status;
    logic [1:0]  cursor_mode;
    scan_line_t  scan_start;
    scan_line_t  scan_end;
    cursor_pos_t cursor_pos;
    logic        text_enabled;
    logic        graphics_enabled;
    logic        display_enabled;
    color_t      background_color;
    logic        bright_colors;
    logic        hsync_s;
    logic        vsync_s;

    bit_sync hsync_sync_i (
        .clk   (clk),
        .reset (reset),
        .d     (vga_hsync),
        .q     (hsync_s)
    );

    bit_sync vsync_sync_i (
        .clk   (clk),
        .reset (reset),
        .d     (vga_vsync),
        .q     (vsync_s)
    );

    // the ack term keeps a held access from being served twice
    assign reg_access = cs & access & ~ack;
    assign sel_index  = reg_access && addr[3:1] == `VGA_OFS_INDEX_VALUE && bytesel[0];
    assign sel_value  = reg_access && addr[3:1] == `VGA_OFS_INDEX_VALUE && bytesel[1];
    assign sel_mode   = reg_access && addr[3:1] == `VGA_OFS_MODE_COLOR && bytesel[0];
    assign sel_color  = reg_access && addr[3:1] == `VGA_OFS_MODE_COLOR && bytesel[1];
    assign sel_status = reg_access && addr[3:1] == `VGA_OFS_STATUS && bytesel[0];

    assign value_byte = wdata[15:8];

    // an index written in the same access takes effect for the value lane
    assign index = (wr_en && sel_index) ? wdata[3:0] : active_index;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ack <= 1'b0;
        end else begin
            ack <= reg_access;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active_index <= '0;
        end else if (wr_en && sel_index) begin
            active_index <= wdata[3:0];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cursor_mode <= '0;
        end else if (wr_en && sel_value && index == `VGA_CRTC_CURSOR_START) begin
            cursor_mode <= value_byte[`VGA_CURSOR_MODE_LSB +: 2];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && sel_value) begin
            case (index)
                `VGA_CRTC_CURSOR_START: scan_start <= value_byte[2:0];
                `VGA_CRTC_CURSOR_END:   scan_end <= value_byte[2:0];
                `VGA_CRTC_POS_HIGH:     cursor_pos[14:8] <= value_byte[6:0];
                `VGA_CRTC_POS_LOW:      cursor_pos[7:0] <= value_byte;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            text_enabled     <= 1'b0;
            graphics_enabled <= 1'b0;
            display_enabled  <= 1'b0;
        end else if (wr_en && sel_mode) begin
            text_enabled     <= wdata[`VGA_MODE_TEXT];
            graphics_enabled <= wdata[`VGA_MODE_GRAPHICS];
            display_enabled  <= wdata[`VGA_MODE_DISPLAY];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && sel_color) begin
            background_color <= value_byte[3:0];
            bright_colors    <= value_byte[4];
        end
    end

    always_comb begin
        case (active_index)
            `VGA_CRTC_CURSOR_START: begin
                index_value = {2'b0, cursor_mode, 1'b0, scan_start};
            end
            `VGA_CRTC_CURSOR_END: index_value = {5'b0, scan_end};
            `VGA_CRTC_POS_HIGH:   index_value = {1'b0, cursor_pos[14:8]};
            `VGA_CRTC_POS_LOW:    index_value = cursor_pos[7:0];
            default:              index_value = 8'b0;
        endcase
    end

    // syncs are active low, status reports retrace as active high
    always_comb begin
        status = 8'b0;
        status[`VGA_STATUS_VSYNC]   = ~vsync_s;
        status[`VGA_STATUS_RETRACE] = ~vsync_s | ~hsync_s;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rdata <= '0;
        end else begin
            rdata <= '0;
            if (!wr_en) begin
                if (sel_index)
                    rdata[7:0] <= {4'b0, active_index};
                if (sel_mode) begin
                    rdata[`VGA_MODE_TEXT]     <= text_enabled;
                    rdata[`VGA_MODE_GRAPHICS] <= graphics_enabled;
                    rdata[`VGA_MODE_DISPLAY]  <= display_enabled;
                end
                if (sel_status)
                    rdata[7:0] <= status;
                if (sel_value)
                    rdata[15:8] <= index_value;
                if (sel_color)
                    rdata[15:8] <= {3'b0, bright_colors, background_color};
            end
        end
    end

    assign cfg.display_enabled   = display_enabled;
    assign cfg.cursor_enabled    = cursor_mode != `VGA_CURSOR_MODE_OFF;
    assign cfg.cursor_pos        = cursor_pos;
    assign cfg.cursor_scan_start = scan_start;
    assign cfg.cursor_scan_end   = scan_end;

endmodule

// ==== design/vga_text_ctrl.sv ====
/* Text display controller top. Bus side runs on clk, raster on vga_clk,
   and only the syncs are synchronised back for status reads */
`timescale 1ns/1ps

module vga_text_ctrl #(
    parameter int cols    = 4,
    parameter int rows    = 2,
    parameter int h_front = 4,
    parameter int h_sync  = 4,
    parameter int h_back  = 4,
    parameter int v_front = 2,
    parameter int v_sync  = 2,
    parameter int v_back  = 2
) (
    input  logic                  clk,
    input  logic                  vga_clk,
    input  logic                  reset,
    input  logic                  cs,
    input  vga_pkg::bus_addr_t    addr,
    input  vga_pkg::bus_data_t    wdata,
    output vga_pkg::bus_data_t    rdata,
    input  vga_pkg::bus_bytesel_t bytesel,
    input  logic                  wr_en,
    input  logic                  access,
    output logic                  ack,
    output logic                  vga_hsync,
    output logic                  vga_vsync,
    output logic                  video_active,
    output logic                  cursor_on
);

    display_cfg_if cfg_if ();

    vga_registers regs_i (
        .clk       (clk),
        .reset     (reset),
        .cs        (cs),
        .addr      (addr),
        .wdata     (wdata),
        .rdata     (rdata),
        .bytesel   (bytesel),
        .wr_en     (wr_en),
        .access    (access),
        .ack       (ack),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .cfg       (cfg_if.regs)
    );

    // sync outputs also feed the status register through its synchronisers
    crtc_timing #(
        .cols    (cols),
        .rows    (rows),
        .h_front (h_front),
        .h_sync  (h_sync),
        .h_back  (h_back),
        .v_front (v_front),
        .v_sync  (v_sync),
        .v_back  (v_back)
    ) crtc_i (
        .vga_clk      (vga_clk),
        .reset        (reset),
        .cfg          (cfg_if.crtc),
        .hsync        (vga_hsync),
        .vsync        (vga_vsync),
        .video_active (video_active),
        .cursor_on    (cursor_on)
    );

endmodule

// ==== include/vga_regs.svh ====
/* Register map of the text display controller. Offsets are word addresses
   decoded from addr[3:1] only, so the chip select has to cover the upper bits */
`ifndef VGA_REGS_SVH
`define VGA_REGS_SVH

// word offsets where lane 0 is the even register and lane 1 the odd one
`define VGA_OFS_INDEX_VALUE 3'd2
`define VGA_OFS_MODE_COLOR  3'd4
`define VGA_OFS_STATUS      3'd5

// CRTC indices reached through the value register
`define VGA_CRTC_CURSOR_START 4'ha
`define VGA_CRTC_CURSOR_END   4'hb
`define VGA_CRTC_POS_HIGH     4'he
`define VGA_CRTC_POS_LOW      4'hf

// mode register bit positions
`define VGA_MODE_TEXT     0
`define VGA_MODE_GRAPHICS 1
`define VGA_MODE_DISPLAY  3

// status register bit positions
`define VGA_STATUS_RETRACE 0
`define VGA_STATUS_VSYNC   3

// cursor mode field inside index 0xA, where mode 1 hides the cursor
`define VGA_CURSOR_MODE_LSB 4
`define VGA_CURSOR_MODE_OFF 2'b01

`endif

// ==== sim/vga_text_ctrl_assertions.sv ====
/* Bus handshake and hsync width checks, bound to the controller top so that
   both clock domains are in reach. Assumes the top's h_sync parameter */
`timescale 1ns/1ps

module vga_text_ctrl_assertions #(
    parameter int h_sync = 4
) (
    input logic               clk,
    input logic               vga_clk,
    input logic               reset,
    input logic               cs,
    input logic               access,
    input logic               ack,
    input vga_pkg::bus_data_t rdata,
    input logic               hsync
);

    // number of failed assertions so far
    int failures = 0;

    // a new access is answered in the next cycle, and only once
    ack_follows_access: assert property (
        @(posedge clk) disable iff (reset) cs && access && !ack |=> ack
    ) else begin
        failures++;
        $error("ack missing one cycle after access");
    end

    ack_single_cycle: assert property (
        @(posedge clk) disable iff (reset) ack |=> !ack
    ) else begin
        failures++;
        $error("ack high for more than one cycle");
    end

    ack_has_access: assert property (
        @(posedge clk) disable iff (reset) $rose(ack) |-> $past(cs && access)
    ) else begin
        failures++;
        $error("ack without a preceding access");
    end

    rdata_idle_zero: assert property (
        @(posedge clk) disable iff (reset) !ack |-> rdata == '0
    ) else begin
        failures++;
        $error("rdata not zero while ack is low");
    end

    hsync_width: assert property (
        @(posedge vga_clk) disable iff (reset) $fell(hsync) |-> (!hsync) [*h_sync] ##1 hsync
    ) else begin
        failures++;
        $error("hsync pulse width differs from h_sync");
    end

endmodule

bind vga_text_ctrl vga_text_ctrl_assertions #(.h_sync(h_sync)) assertions_i (
    .clk     (clk),
    .vga_clk (vga_clk),
    .reset   (reset),
    .cs      (cs),
    .access  (access),
    .ack     (ack),
    .rdata   (rdata),
    .hsync   (vga_hsync)
);

// ==== sim/vga_text_ctrl_tb.sv ====
/* Testbench for the text display controller at its default parameters.
   Frame checks assume 4x2 characters, 4 pixel porches and 2 line porches */
`timescale 1ns/1ps
`include "vga_regs.svh"

module vga_text_ctrl_tb;
    import vga_pkg::*;

    localparam int cols         = 4;
    localparam int rows         = 2;
    localparam int line_pixels  = cols * 8 + 4 + 4 + 4;
    localparam int frame_lines  = rows * 8 + 2 + 2 + 2;
    localparam int frame_pixels = line_pixels * frame_lines;
    localparam logic [2:0] ofs_index  = `VGA_OFS_INDEX_VALUE;
    localparam logic [2:0] ofs_mode   = `VGA_OFS_MODE_COLOR;
    localparam logic [2:0] ofs_status = `VGA_OFS_STATUS;

    typedef struct {
        string        name;
        logic [2:0]   ofs;
        bus_bytesel_t bytesel;
        bus_data_t    wdata;
        logic         write;
        bus_data_t    expected;
        logic         check;
    } bus_op_t;

    logic         clk;
    logic         vga_clk;
    logic         reset;
    logic         cs;
    bus_addr_t    addr;
    bus_data_t    wdata;
    bus_data_t    rdata;
    bus_bytesel_t bytesel;
    logic         wr_en;
    logic         access;
    logic         ack;
    logic         vga_hsync;
    logic         vga_vsync;
    logic         video_active;
    logic         cursor_on;

    bus_op_t     ops[$];
    int          checks = 0;
    int          errors = 0;
    int          cycle_count = 0;
    logic [31:0] rng = 32'h6dd0;

    vga_text_ctrl dut_i (
        .clk          (clk),
        .vga_clk      (vga_clk),
        .reset        (reset),
        .cs           (cs),
        .addr         (addr),
        .wdata        (wdata),
        .rdata        (rdata),
        .bytesel      (bytesel),
        .wr_en        (wr_en),
        .access       (access),
        .ack          (ack),
        .vga_hsync    (vga_hsync),
        .vga_vsync    (vga_vsync),
        .video_active (video_active),
        .cursor_on    (cursor_on)
    );

    always #2 clk = ~clk;
    always #3 vga_clk = ~vga_clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= ops.size() * 8 + 12 * frame_pixels * 2) begin
            $display("timeout: run did not finish within %0d clk cycles", cycle_count);
            $display("checks: %0d, errors: %0d", checks, errors);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error: %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        end
    endtask

    task automatic add_op(input string name, input logic [2:0] ofs, input bus_bytesel_t bs,
                          input bus_data_t wd, input logic wr, input bus_data_t exp,
                          input logic chk);
        bus_op_t op;
        op.name     = name;
        op.ofs      = ofs;
        op.bytesel  = bs;
        op.wdata    = wd;
        op.write    = wr;
        op.expected = exp;
        op.check    = chk;
        ops.push_back(op);
    endtask

    // drives one access, waits for ack and releases the bus again
    task automatic bus_access(input string name, input logic [2:0] ofs, input bus_bytesel_t bs,
                              input bus_data_t wd, input logic wr, output bus_data_t rd);
        int waited;
        @(negedge clk);
        cs      = 1'b1;
        access  = 1'b1;
        addr    = bus_addr_t'(ofs);
        bytesel = bs;
        wdata   = wd;
        wr_en   = wr;
        waited  = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!ack && waited < 4);
        rd = rdata;
        if (!ack) begin
            errors++;
            $display("bus timeout: %s got no ack within 4 cycles", name);
        end
        cs     = 1'b0;
        access = 1'b0;
        wr_en  = 1'b0;
        @(negedge clk);
        if (ack) begin
            errors++;
            $display("%s: ack stayed high for more than one cycle", name);
        end
    endtask

    task automatic write_crtc(input reg_index_t index, input logic [7:0] value);
        bus_data_t rd;
        bus_access("crtc write", ofs_index, 2'b11, {value, 4'h0, index}, 1'b1, rd);
        check_equal("crtc write data", 32'h0, 32'(rd));
    endtask

    // the value lane answers on the high byte and the index lane on the low byte
    task automatic build_table();
        add_op("index after reset", ofs_index, 2'b01, 16'h0000, 1'b0, 16'h0000, 1'b1);
        add_op("mode after reset", ofs_mode, 2'b01, 16'h0000, 1'b0, 16'h0000, 1'b1);
        add_op("value of index 0", ofs_index, 2'b10, 16'h0000, 1'b0, 16'h0000, 1'b1);
        add_op("select index a", ofs_index, 2'b01, 16'h000a, 1'b1, 16'h0000, 1'b1);
        add_op("index readback", ofs_index, 2'b01, 16'h0000, 1'b0, 16'h000a, 1'b1);
        add_op("cursor start write", ofs_index, 2'b10, 16'h3200, 1'b1, 16'h0000, 1'b1);
        add_op("cursor start read", ofs_index, 2'b11, 16'h0000, 1'b0, 16'h320a, 1'b1);
        add_op("index b with end", ofs_index, 2'b11, 16'h050b, 1'b1, 16'h0000, 1'b1);
        add_op("cursor end read", ofs_index, 2'b11, 16'h0000, 1'b0, 16'h050b, 1'b1);
        add_op("position high write", ofs_index, 2'b11, 16'hff0e, 1'b1, 16'h0000, 1'b1);
        add_op("position high read", ofs_index, 2'b11, 16'h0000, 1'b0, 16'h7f0e, 1'b1);
        add_op("position low write", ofs_index, 2'b11, 16'ha50f, 1'b1, 16'h0000, 1'b1);
        add_op("position low read", ofs_index, 2'b11, 16'h0000, 1'b0, 16'ha50f, 1'b1);
        add_op("undefined index write", ofs_index, 2'b11, 16'hff03, 1'b1, 16'h0000, 1'b1);
        add_op("undefined index read", ofs_index, 2'b11, 16'h0000, 1'b0, 16'h0003, 1'b1);
        add_op("mode colour write", ofs_mode, 2'b11, 16'h3cff, 1'b1, 16'h0000, 1'b1);
        add_op("mode colour read", ofs_mode, 2'b11, 16'h0000, 1'b0, 16'h1c0b, 1'b1);
        add_op("display only write", ofs_mode, 2'b01, 16'h0008, 1'b1, 16'h0000, 1'b1);
        add_op("display only read", ofs_mode, 2'b01, 16'h0000, 1'b0, 16'h0008, 1'b1);
    endtask

    task automatic apply_table();
        bus_data_t rd;
        foreach (ops[i]) begin
            bus_access(ops[i].name, ops[i].ofs, ops[i].bytesel, ops[i].wdata,
                       ops[i].write, rd);
            if (ops[i].check)
                check_equal(ops[i].name, 32'(ops[i].expected), 32'(rd));
        end
    endtask

    // counts one whole frame from a vsync falling edge to the next
    task automatic check_frame(input string name, input int exp_active, input int exp_cursor);
        int   pixels;
        int   hpulses;
        int   active;
        int   cursor;
        logic prev_h;
        logic prev_v;
        logic frame_end;
        do begin
            prev_v = vga_vsync;
            @(negedge vga_clk);
        end while (!(prev_v && !vga_vsync));
        pixels  = 0;
        hpulses = 0;
        active  = 0;
        cursor  = 0;
        prev_h  = vga_hsync;
        prev_v  = vga_vsync;
        do begin
            pixels++;
            if (video_active)
                active++;
            if (cursor_on)
                cursor++;
            @(negedge vga_clk);
            if (prev_h && !vga_hsync)
                hpulses++;
            frame_end = prev_v && !vga_vsync;
            prev_h    = vga_hsync;
            prev_v    = vga_vsync;
        end while (!frame_end);
        check_equal({name, " pixels"}, frame_pixels, pixels);
        check_equal({name, " hsync pulses"}, frame_lines, hpulses);
        check_equal({name, " video active"}, exp_active, active);
        check_equal({name, " cursor"}, exp_cursor, cursor);
    endtask

    task automatic sweep_cursor();
        bus_data_t rd;
        int        pos;
        int        start;
        int        stop;
        for (int k = 0; k < 3; k++) begin
            rng   = xorshift32(rng);
            pos   = rng % (cols * rows);
            rng   = xorshift32(rng);
            start = rng % 8;
            stop  = start + (rng >> 8) % (8 - start);
            write_crtc(`VGA_CRTC_CURSOR_START, 8'(start));
            write_crtc(`VGA_CRTC_CURSOR_END, 8'(stop));
            write_crtc(`VGA_CRTC_POS_HIGH, 8'h00);
            write_crtc(`VGA_CRTC_POS_LOW, 8'(pos));
            check_frame($sformatf("cursor %0d lines %0d-%0d", pos, start, stop),
                        cols * rows * 64, 8 * (stop - start + 1));
        end
        // cursor mode 1 sits in bits 5:4 of index 0xA
        write_crtc(`VGA_CRTC_CURSOR_START, 8'h10 | 8'(start));
        check_frame("cursor mode 1", cols * rows * 64, 0);
        write_crtc(`VGA_CRTC_CURSOR_START, 8'(start));
        bus_access("display off", ofs_mode, 2'b01, 16'h0001, 1'b1, rd);
        check_frame("display off", 0, 0);
    endtask

    task automatic poll_status();
        bus_data_t rd;
        logic      seen_set;
        logic      seen_clear;
        int        polls;
        seen_set   = 1'b0;
        seen_clear = 1'b0;
        polls      = 0;
        // three clk cycles per read, so 1000 reads cover a little over two frames
        while (!(seen_set && seen_clear) && polls < 1000) begin
            bus_access("status poll", ofs_status, 2'b01, 16'h0000, 1'b0, rd);
            polls++;
            if (rd[`VGA_STATUS_VSYNC])
                seen_set = 1'b1;
            else
                seen_clear = 1'b1;
            if (rd[`VGA_STATUS_VSYNC] && !rd[`VGA_STATUS_RETRACE]) begin
                errors++;
                $display("status read has the vsync bit set but the retrace bit clear");
            end
            check_equal("status unused bits", 32'h0, 32'(rd & 16'hfff6));
        end
        if (!(seen_set && seen_clear)) begin
            errors++;
            $display("status vsync bit was not seen both set and clear within two frames");
        end
    endtask

    initial begin
        clk     = 1'b0;
        vga_clk = 1'b0;
        reset   = 1'b1;
        cs      = 1'b0;
        access  = 1'b0;
        addr    = '0;
        wdata   = '0;
        bytesel = '0;
        wr_en   = 1'b0;
        build_table();
        repeat (16) @(negedge clk);
        reset = 1'b0;
        apply_table();
        sweep_cursor();
        poll_status();
        errors += dut_i.assertions_i.failures;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+include
design/vga_pkg.sv
design/display_cfg_if.sv
design/bit_sync.sv
design/vga_registers.sv
design/crtc_timing.sv
design/vga_text_ctrl.sv
sim/vga_text_ctrl_assertions.sv
sim/vga_text_ctrl_tb.sv
